/* Makefile */
SIM = obj_dir/VitemMapTb

.PHONY: all run clean

all: run

$(SIM): all.f $(wildcard source/*.sv) $(wildcard tb/*.sv)
	verilator --binary --timing --assert -Wno-fatal -f all.f --top-module itemMapTb -Mdir obj_dir

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "All tests passed!" sim.log

clean:
	rm -rf obj_dir sim.log

/* all.f */
source/itemMapPkg.sv
source/itemPlacer.sv
source/hookMovePort.sv
source/tableArbiter.sv
source/itemTable.sv
source/itemMapTop.sv
tb/itemMap_sva.sv
tb/itemMapTb.sv

/* source/hookMovePort.sv */
module hookMovePort (
    input  logic                 clock,
    input  logic                 generateEn,
    input  itemMapPkg::apbReqT   apbReq,
    output itemMapPkg::apbRspT   apbRsp,
    output itemMapPkg::tableReqT tableReq,
    input  logic                 grant,
    input  itemMapPkg::itemT     readItem
);
    import itemMapPkg::*;

    typedef enum logic [2:0] {
        stIdle,
        stRead,
        stCheck,
        stWrite,
        stDone
    } portStateT;

    portStateT state;
    logic isWrite;
    logic errReg;
    itemIndexT readIdx;
    itemIndexT targetIdx;
    moveReqT moveReg;
    itemT movedItem;
    itemT updItem;
    itemT rdataReg;

    // moves address the item through the command, reads through addr
    assign targetIdx = isWrite ? moveReg.index : readIdx;

    // capture the transfer in its setup cycle
    always_ff @(posedge clock) begin
        if (state == stIdle && apbReq.sel && !apbReq.enable) begin
            isWrite <= apbReq.write;
            readIdx <= apbReq.addr;
            moveReg <= moveReqT'(apbReq.wdata);
        end
        if (state == stCheck) begin
            rdataReg <= readItem;
            updItem <= movedItem;
        end
    end

    // deltas wrap with the field width
    always_comb begin
        movedItem = readItem;
        movedItem.left = readItem.left + moveReg.dx[8:0];
        movedItem.top = readItem.top + moveReg.dy[7:0];
        movedItem.moved = moveReg.moved;
        movedItem.visible = moveReg.visible;
    end

    always_ff @(posedge clock or negedge generateEn) begin
        if (!generateEn) begin
            state <= stIdle;
            errReg <= 1'b0;
        end else begin
            case (state)
                stIdle: begin
                    if (apbReq.sel && !apbReq.enable) begin
                        state <= stRead;
                    end
                end
                stRead: begin
                    if (grant) begin
                        state <= stCheck;
                    end
                end
                // hidden items reject moves untouched
                stCheck: begin
                    errReg <= isWrite && !readItem.visible;
                    state <= (isWrite && readItem.visible) ? stWrite : stDone;
                end
                stWrite: begin
                    if (grant) begin
                        state <= stDone;
                    end
                end
                stDone: state <= stIdle;
                default: state <= stIdle;
            endcase
        end
    end

    // held through read, check and write so the move is atomic
    always_comb begin
        tableReq = '0;
        tableReq.valid = (state == stRead) || (state == stCheck) || (state == stWrite);
        tableReq.write = (state == stWrite);
        tableReq.index = targetIdx;
        tableReq.item = updItem;
    end

    always_comb begin
        apbRsp = '0;
        apbRsp.ready = (state == stDone);
        apbRsp.slverr = (state == stDone) && errReg;
        apbRsp.rdata = rdataReg;
    end

endmodule

/* source/itemMapPkg.sv */
package itemMapPkg;

    // table depth
    localparam int maxItems = 32;

    // playfield grid in cells
    localparam int gridCols = 20;
    localparam int gridRows = 10;

    // 16 pixels per cell
    localparam int cellShift = 4;

    // every top coordinate sits below the status bar
    localparam int topOffset = 80;

    // position generator, x <= x * mul + add
    localparam logic [15:0] lcgSeed = 16'd173;
    localparam logic [15:0] lcgMul = 16'd43;
    localparam logic [15:0] lcgAdd = 16'd181;

    typedef logic [4:0] itemIndexT;

    typedef enum logic [1:0] {
        stone = 2'd0,
        gold = 2'd1,
        diamond = 2'd2
    } itemKindT;

    // one table entry, 32 bits
    typedef struct packed {
        logic [8:0] left;
        logic [7:0] top;
        itemKindT kind;
        logic visible;
        logic moved;
        // spare bits, always zero
        logic [10:0] pad;
    } itemT;

    // single table access
    typedef struct packed {
        logic valid;
        logic write;
        itemIndexT index;
        itemT item;
    } tableReqT;

    // move command carried in apb wdata
    typedef struct packed {
        itemIndexT index;
        logic signed [9:0] dx;
        logic signed [9:0] dy;
        logic moved;
        logic visible;
        logic [4:0] pad;
    } moveReqT;

    typedef struct packed {
        logic sel;
        logic enable;
        logic write;
        itemIndexT addr;
        logic [31:0] wdata;
    } apbReqT;

    typedef struct packed {
        logic ready;
        logic slverr;
        logic [31:0] rdata;
    } apbRspT;

    // table owners
    typedef enum logic [1:0] {
        placer = 2'd0,
        hook0 = 2'd1,
        hook1 = 2'd2
    } requesterT;

endpackage

/* source/itemMapTop.sv */
module itemMapTop (
    input  logic               clock,
    input  logic               generateEn,
    input  logic [4:0]         stoneQuantity,
    input  logic [4:0]         goldQuantity,
    input  logic [4:0]         diamondQuantity,
    input  itemMapPkg::apbReqT hookBus0,
    input  itemMapPkg::apbReqT hookBus1,
    output itemMapPkg::apbRspT hookRsp0,
    output itemMapPkg::apbRspT hookRsp1,
    output logic               mapReady
);
    import itemMapPkg::*;

    // requests into the arbiter
    tableReqT placerReq;
    tableReqT hookReq0;
    tableReqT hookReq1;
    // granted request into the table
    tableReqT arbReq;

    logic placerGrant;
    logic hookGrant0;
    logic hookGrant1;

    // shared read data, each owner knows when it is its own
    itemT readItem;

    itemPlacer u_itemPlacer (
        .clock           (clock),
        .generateEn      (generateEn),
        .stoneQuantity   (stoneQuantity),
        .goldQuantity    (goldQuantity),
        .diamondQuantity (diamondQuantity),
        .tableReq        (placerReq),
        .grant           (placerGrant),
        .readItem        (readItem),
        .mapReady        (mapReady)
    );

    hookMovePort u_hookPort0 (
        .clock      (clock),
        .generateEn (generateEn),
        .apbReq     (hookBus0),
        .apbRsp     (hookRsp0),
        .tableReq   (hookReq0),
        .grant      (hookGrant0),
        .readItem   (readItem)
    );

    hookMovePort u_hookPort1 (
        .clock      (clock),
        .generateEn (generateEn),
        .apbReq     (hookBus1),
        .apbRsp     (hookRsp1),
        .tableReq   (hookReq1),
        .grant      (hookGrant1),
        .readItem   (readItem)
    );

    tableArbiter u_tableArbiter (
        .clock       (clock),
        .generateEn  (generateEn),
        .placerReq   (placerReq),
        .hookReq0    (hookReq0),
        .hookReq1    (hookReq1),
        .placerGrant (placerGrant),
        .hookGrant0  (hookGrant0),
        .hookGrant1  (hookGrant1),
        .tableReq    (arbReq)
    );

    itemTable u_itemTable (
        .clock      (clock),
        .generateEn (generateEn),
        .tableReq   (arbReq),
        .readItem   (readItem)
    );

endmodule

/* source/itemPlacer.sv */
module itemPlacer (
    input  logic                 clock,
    input  logic                 generateEn,
    input  logic [4:0]           stoneQuantity,
    input  logic [4:0]           goldQuantity,
    input  logic [4:0]           diamondQuantity,
    output itemMapPkg::tableReqT tableReq,
    input  logic                 grant,
    input  itemMapPkg::itemT     readItem,
    output logic                 mapReady
);
    import itemMapPkg::*;

    typedef enum logic [2:0] {
        stIdle,
        stClear,
        stDraw,
        stCheckRd,
        stCheckCmp,
        stPlace,
        stDone
    } placerStateT;

    placerStateT state;
    logic [15:0] lcgState;
    itemIndexT clearIdx;
    itemIndexT checkIdx;
    logic [5:0] placedCount;
    logic [5:0] targetCount;
    logic [6:0] quantitySum;
    logic [4:0] rawCol;
    logic [4:0] foldCol;
    logic [3:0] rawRow;
    logic [3:0] foldRow;
    logic [8:0] candLeft;
    logic [7:0] candTop;
    itemKindT candKind;
    itemT newItem;
    logic hit;

    // generator free runs, so draw timing adds to the randomness
    always_ff @(posedge clock or negedge generateEn) begin
        if (!generateEn) begin
            lcgState <= lcgSeed;
        end else begin
            lcgState <= lcgState * lcgMul + lcgAdd;
        end
    end

    // top 5 bits give the column, next 4 the row
    assign rawCol = lcgState[15:11];
    assign rawRow = lcgState[10:7];
    // fold out-of-grid values back in
    assign foldCol = (rawCol >= 5'(gridCols)) ? rawCol - 5'(32 - gridCols) : rawCol;
    assign foldRow = (rawRow >= 4'(gridRows)) ? rawRow - 4'(16 - gridRows) : rawRow;

    // never place more than the table holds
    assign quantitySum = 7'(stoneQuantity) + 7'(goldQuantity) + 7'(diamondQuantity);
    assign targetCount = (quantitySum > 7'(maxItems)) ? 6'(maxItems) : quantitySum[5:0];

    // stones first, then gold, diamonds fill the rest
    always_comb begin
        if (7'(placedCount) < 7'(stoneQuantity)) begin
            candKind = stone;
        end else if (7'(placedCount) < 7'(stoneQuantity) + 7'(goldQuantity)) begin
            candKind = gold;
        end else begin
            candKind = diamond;
        end
    end

    // same cell as an earlier item
    assign hit = (readItem.left == candLeft) && (readItem.top == candTop);

    // latch the candidate in pixels
    always_ff @(posedge clock) begin
        if (state == stDraw) begin
            candLeft <= 9'(foldCol) << cellShift;
            candTop <= (8'(foldRow) << cellShift) + 8'(topOffset);
        end
    end

    always_ff @(posedge clock or negedge generateEn) begin
        if (!generateEn) begin
            state <= stIdle;
            clearIdx <= '0;
            checkIdx <= '0;
            placedCount <= '0;
        end else begin
            case (state)
                stIdle: state <= stClear;
                // zero every entry first
                stClear: begin
                    if (grant) begin
                        clearIdx <= clearIdx + 1'b1;
                        if (clearIdx == itemIndexT'(maxItems - 1)) begin
                            state <= (targetCount == '0) ? stDone : stDraw;
                        end
                    end
                end
                stDraw: begin
                    checkIdx <= '0;
                    state <= (placedCount == '0) ? stPlace : stCheckRd;
                end
                stCheckRd: begin
                    if (grant) begin
                        state <= stCheckCmp;
                    end
                end
                // readItem holds entry checkIdx here
                stCheckCmp: begin
                    if (hit) begin
                        state <= stDraw;
                    end else if (6'(checkIdx) == placedCount - 1'b1) begin
                        state <= stPlace;
                    end else begin
                        checkIdx <= checkIdx + 1'b1;
                        state <= stCheckRd;
                    end
                end
                stPlace: begin
                    if (grant) begin
                        placedCount <= placedCount + 1'b1;
                        state <= (placedCount + 1'b1 == targetCount) ? stDone : stDraw;
                    end
                end
                stDone: state <= stDone;
                default: state <= stIdle;
            endcase
        end
    end

    always_comb begin
        newItem = '0;
        newItem.left = candLeft;
        newItem.top = candTop;
        newItem.kind = candKind;
        newItem.visible = 1'b1;
        newItem.moved = 1'b0;
    end

    // request stays valid from clear to done so no hook slips in
    always_comb begin
        tableReq = '0;
        case (state)
            stClear: begin
                tableReq.valid = 1'b1;
                tableReq.write = 1'b1;
                tableReq.index = clearIdx;
            end
            stDraw, stCheckRd, stCheckCmp: begin
                tableReq.valid = 1'b1;
                tableReq.index = checkIdx;
            end
            stPlace: begin
                tableReq.valid = 1'b1;
                tableReq.write = 1'b1;
                tableReq.index = placedCount[4:0];
                tableReq.item = newItem;
            end
            default: tableReq = '0;
        endcase
    end

    assign mapReady = (state == stDone);

endmodule

/* source/itemTable.sv */
module itemTable (
    input  logic                 clock,
    input  logic                 generateEn,
    input  itemMapPkg::tableReqT tableReq,
    output itemMapPkg::itemT     readItem
);
    import itemMapPkg::*;

    // one entry per item slot
    itemT mem [0:maxItems-1];

    logic doWrite;
    logic doRead;

    assign doWrite = tableReq.valid && tableReq.write;
    assign doRead = tableReq.valid && !tableReq.write;

    // write lands at the edge
    always_ff @(posedge clock) begin
        if (doWrite) begin
            mem[tableReq.index] <= tableReq.item;
        end
    end

    // registered read, data one cycle after the request
    // output holds between reads
    always_ff @(posedge clock or negedge generateEn) begin
        if (!generateEn) begin
            readItem <= '0;
        end else if (doRead) begin
            readItem <= mem[tableReq.index];
        end
    end

endmodule

/* source/tableArbiter.sv */
module tableArbiter (
    input  logic                 clock,
    input  logic                 generateEn,
    input  itemMapPkg::tableReqT placerReq,
    input  itemMapPkg::tableReqT hookReq0,
    input  itemMapPkg::tableReqT hookReq1,
    output logic                 placerGrant,
    output logic                 hookGrant0,
    output logic                 hookGrant1,
    output itemMapPkg::tableReqT tableReq
);
    import itemMapPkg::*;

    requesterT owner;
    requesterT pick;
    logic ownerActive;
    logic ownerValid;
    logic holding;
    logic anyGrant;
    // 1 when hook1 wins the next tie
    logic hookTurn;

    always_comb begin
        case (owner)
            placer: ownerValid = placerReq.valid;
            hook0: ownerValid = hookReq0.valid;
            hook1: ownerValid = hookReq1.valid;
            default: ownerValid = 1'b0;
        endcase
    end

    // last owner keeps the table while it still asks
    assign holding = ownerActive && ownerValid;

    always_comb begin
        pick = owner;
        anyGrant = 1'b1;
        if (holding) begin
            pick = owner;
        end else if (placerReq.valid) begin
            pick = placer;
        end else if (hookReq0.valid && hookReq1.valid) begin
            pick = hookTurn ? hook1 : hook0;
        end else if (hookReq0.valid) begin
            pick = hook0;
        end else if (hookReq1.valid) begin
            pick = hook1;
        end else begin
            anyGrant = 1'b0;
        end
    end

    always_ff @(posedge clock or negedge generateEn) begin
        if (!generateEn) begin
            owner <= placer;
            ownerActive <= 1'b0;
            hookTurn <= 1'b0;
        end else begin
            owner <= pick;
            ownerActive <= anyGrant;
            // fresh hook grant hands the next tie to the other hook
            if (anyGrant && !holding && pick != placer) begin
                hookTurn <= (pick == hook0);
            end
        end
    end

    assign placerGrant = anyGrant && (pick == placer);
    assign hookGrant0 = anyGrant && (pick == hook0);
    assign hookGrant1 = anyGrant && (pick == hook1);

    // forward only the granted request
    always_comb begin
        tableReq = '0;
        if (anyGrant) begin
            case (pick)
                placer: tableReq = placerReq;
                hook0: tableReq = hookReq0;
                hook1: tableReq = hookReq1;
                default: tableReq = '0;
            endcase
        end
    end

endmodule

/* tb/itemMapTb.sv */
module itemMapTb;
    timeunit 1ns;
    timeprecision 100ps;

    import itemMapPkg::*;

    // placement needs well under 2000 cycles and the tests about 150
    // accesses of some 10 cycles each, so this leaves a wide margin
    localparam int cycleLimit = 20000;

    logic clock;
    logic generateEn;
    logic [4:0] stoneQuantity;
    logic [4:0] goldQuantity;
    logic [4:0] diamondQuantity;
    apbReqT hookBus0;
    apbReqT hookBus1;
    apbRspT hookRsp0;
    apbRspT hookRsp1;
    logic mapReady;

    // what the compare process expects for one access
    typedef struct packed {
        logic checkData;
        logic [31:0] data;
        logic err;
    } expectT;

    expectT expQ0[$];
    expectT expQ1[$];

    // model of the item table
    itemT model [0:maxItems-1];
    itemT readBack [0:maxItems-1];
    logic [31:0] rngState;
    int usedCount;
    int errorCount;
    int testCount;
    int testsFailed;
    int testStartErrors;
    int cycleCount;

    itemMapTop u_itemMapTop (
        .clock           (clock),
        .generateEn      (generateEn),
        .stoneQuantity   (stoneQuantity),
        .goldQuantity    (goldQuantity),
        .diamondQuantity (diamondQuantity),
        .hookBus0        (hookBus0),
        .hookBus1        (hookBus1),
        .hookRsp0        (hookRsp0),
        .hookRsp1        (hookRsp1),
        .mapReady        (mapReady)
    );

    // 4 ns period
    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    initial begin
        cycleCount = 0;
        while (cycleCount < cycleLimit) begin
            @(posedge clock);
            cycleCount++;
        end
        $display("run stopped after %0d cycles without finishing", cycleLimit);
        $display("Test failures found");
        $finish;
    end

    // lcg, upper half is the better mixed part
    function automatic logic [15:0] nextRandom();
        rngState = rngState * 32'd1664525 + 32'd1013904223;
        return rngState[31:16];
    endfunction

    // stones first, gold next, diamonds after
    function automatic itemKindT expectedKind(int idx);
        if (idx < int'(stoneQuantity)) begin
            return stone;
        end
        if (idx < int'(stoneQuantity) + int'(goldQuantity)) begin
            return gold;
        end
        return diamond;
    endfunction

    function automatic int wrapAdd(int value, int delta, int span);
        int sum;
        sum = (value + delta) % span;
        if (sum < 0) begin
            sum += span;
        end
        return sum;
    endfunction

    // expected item after a move, hidden items stay as they are
    function automatic itemT expectedMove(itemT cur, moveReqT cmd);
        itemT nxt;
        int dxVal;
        int dyVal;
        nxt = cur;
        dxVal = int'($signed(cmd.dx));
        dyVal = int'($signed(cmd.dy));
        if (cur.visible) begin
            nxt.left = 9'(wrapAdd(int'(cur.left), dxVal, 512));
            nxt.top = 8'(wrapAdd(int'(cur.top), dyVal, 256));
            nxt.moved = cmd.moved;
            nxt.visible = cmd.visible;
        end
        return nxt;
    endfunction

    function automatic int findVisible(int from);
        for (int i = from; i < maxItems; i++) begin
            if (model[i].visible) begin
                return i;
            end
        end
        return -1;
    endfunction

    task automatic driveBus(input int port, input apbReqT req);
        if (port == 0) begin
            hookBus0 = req;
        end else begin
            hookBus1 = req;
        end
    endtask

    // one apb transfer, starts and ends 1 ns after an edge
    task automatic apbAccess(input int port, input logic write, input itemIndexT addr,
            input logic [31:0] wdata, input expectT exp, output logic [31:0] rdata);
        apbReqT req;
        apbRspT rsp;
        if (port == 0) begin
            expQ0.push_back(exp);
        end else begin
            expQ1.push_back(exp);
        end
        req = '0;
        req.sel = 1'b1;
        req.write = write;
        req.addr = addr;
        req.wdata = wdata;
        // setup cycle
        driveBus(port, req);
        @(posedge clock);
        #1;
        req.enable = 1'b1;
        driveBus(port, req);
        // access phase holds until ready
        do begin
            @(posedge clock);
            #1;
            rsp = (port == 0) ? hookRsp0 : hookRsp1;
        end while (!rsp.ready);
        rdata = rsp.rdata;
        @(posedge clock);
        #1;
        driveBus(port, '0);
    endtask

    task automatic moveItem(input int port, input itemIndexT idx, input logic signed [9:0] dx,
            input logic signed [9:0] dy, input logic moved, input logic visible);
        moveReqT cmd;
        expectT exp;
        logic [31:0] rdata;
        cmd = '0;
        cmd.index = idx;
        cmd.dx = dx;
        cmd.dy = dy;
        cmd.moved = moved;
        cmd.visible = visible;
        exp = '0;
        // hidden item answers with slverr
        exp.err = !model[idx].visible;
        model[idx] = expectedMove(model[idx], cmd);
        apbAccess(port, 1'b1, idx, 32'(cmd), exp, rdata);
    endtask

    task automatic readCheck(input int port, input itemIndexT idx);
        expectT exp;
        logic [31:0] rdata;
        exp = '0;
        exp.checkData = 1'b1;
        exp.data = 32'(model[idx]);
        apbAccess(port, 1'b0, idx, 32'd0, exp, rdata);
    endtask

    task automatic checkResponse(input int port, input apbRspT rsp);
        expectT exp;
        if (rsp.ready) begin
            if (!mapReady) begin
                errorCount++;
                $display("error at %0t: port %0d answered before the map was ready",
                    $time, port);
            end
            if ((port == 0 && expQ0.size() == 0) || (port == 1 && expQ1.size() == 0)) begin
                errorCount++;
                $display("port %0d gave a response while no access was pending", port);
            end else begin
                if (port == 0) begin
                    exp = expQ0.pop_front();
                end else begin
                    exp = expQ1.pop_front();
                end
                if (rsp.slverr !== exp.err) begin
                    errorCount++;
                    $display("error at %0t: port %0d slverr %b, expected %b",
                        $time, port, rsp.slverr, exp.err);
                end
                if (exp.checkData && rsp.rdata !== exp.data) begin
                    errorCount++;
                    $display("error at %0t: port %0d read %h, expected %h",
                        $time, port, rsp.rdata, exp.data);
                end
            end
        end
    endtask

    // ready is a register decode, stable at the falling edge
    always @(negedge clock) begin
        if (generateEn) begin
            checkResponse(0, hookRsp0);
            checkResponse(1, hookRsp1);
        end
    end

    task automatic beginTest();
        testStartErrors = errorCount;
    endtask

    task automatic endTest(input string name);
        testCount++;
        if (errorCount == testStartErrors) begin
            $display("test %0d %s: passed", testCount, name);
        end else begin
            testsFailed++;
            $display("test %0d %s: failed with %0d errors", testCount, name,
                errorCount - testStartErrors);
        end
    endtask

    task automatic reportError(input string msg);
        errorCount++;
        $display("error at %0t: %s", $time, msg);
    endtask

    initial begin
        logic [31:0] rdata;
        logic [31:0] stalledData;
        logic [15:0] r;
        itemIndexT idx;
        int visibleCount;
        int idxA;
        int idxB;
        int idxC;
        generateEn = 1'b0;
        hookBus0 = '0;
        hookBus1 = '0;
        stoneQuantity = 5'd5;
        goldQuantity = 5'd5;
        diamondQuantity = 5'd5;
        rngState = 32'hd607;
        errorCount = 0;
        testCount = 0;
        testsFailed = 0;
        testStartErrors = 0;
        usedCount = int'(stoneQuantity) + int'(goldQuantity) + int'(diamondQuantity);
        if (usedCount > maxItems) begin
            usedCount = maxItems;
        end
        repeat (10) @(posedge clock);
        #1;
        generateEn = 1'b1;

        // issued while the placer still owns the table
        beginTest();
        if (mapReady) begin
            reportError("mapReady high right after reset");
        end
        apbAccess(0, 1'b0, 5'd0, 32'd0, '0, stalledData);
        if (!mapReady) begin
            reportError("stalled read finished with mapReady low");
        end
        endTest("read during generation");

        beginTest();
        for (int i = 0; i < maxItems; i++) begin
            apbAccess(0, 1'b0, itemIndexT'(i), 32'd0, '0, rdata);
            readBack[i] = itemT'(rdata);
        end
        visibleCount = 0;
        for (int i = 0; i < maxItems; i++) begin
            if (readBack[i].visible) begin
                visibleCount++;
            end
            if (i < usedCount) begin
                if (readBack[i].kind !== expectedKind(i) || readBack[i].moved !== 1'b0) begin
                    reportError($sformatf("entry %0d has wrong kind or moved flag", i));
                end
                if (readBack[i].pad !== '0) begin
                    reportError($sformatf("entry %0d has nonzero padding", i));
                end
            end else if (readBack[i] !== '0) begin
                reportError($sformatf("unused entry %0d is %h", i, readBack[i]));
            end
        end
        if (visibleCount != usedCount) begin
            reportError($sformatf("%0d visible items, expected %0d", visibleCount, usedCount));
        end
        if (readBack[0] !== itemT'(stalledData)) begin
            reportError("stalled read differs from entry 0");
        end
        endTest("map contents");

        beginTest();
        for (int i = 0; i < usedCount; i++) begin
            if (int'(readBack[i].left) % 16 != 0 || int'(readBack[i].left) > 304) begin
                reportError($sformatf("entry %0d left %0d off grid", i, readBack[i].left));
            end
            if (int'(readBack[i].top) < 80 || int'(readBack[i].top) > 224 ||
                    (int'(readBack[i].top) - topOffset) % 16 != 0) begin
                reportError($sformatf("entry %0d top %0d off grid", i, readBack[i].top));
            end
            for (int j = 0; j < i; j++) begin
                if (readBack[i].left == readBack[j].left && readBack[i].top == readBack[j].top) begin
                    reportError($sformatf("entries %0d and %0d share a cell", j, i));
                end
            end
        end
        endTest("distinct positions");
        for (int i = 0; i < maxItems; i++) begin
            model[i] = readBack[i];
        end

        // random moves, about one in eight hides its item
        beginTest();
        for (int n = 0; n < 24; n++) begin
            r = nextRandom();
            idx = itemIndexT'(int'(r) % usedCount);
            moveItem(0, idx, 10'(nextRandom()), 10'(nextRandom()), r[8], r[15:13] != 3'd0);
            readCheck(0, idx);
        end
        endTest("random moves on port 0");

        beginTest();
        idxA = findVisible(0);
        idxB = (idxA < 0) ? -1 : findVisible(idxA + 1);
        idxC = (idxB < 0) ? -1 : findVisible(idxB + 1);
        if (idxC < 0) begin
            reportError("too few visible items left for the concurrent moves");
        end else begin
            fork
                moveItem(0, itemIndexT'(idxA), 10'(nextRandom()), 10'(nextRandom()), 1'b1, 1'b1);
                moveItem(1, itemIndexT'(idxB), 10'(nextRandom()), 10'(nextRandom()), 1'b0, 1'b1);
            join
            readCheck(0, itemIndexT'(idxB));
            readCheck(1, itemIndexT'(idxA));
            // same item, both deltas must land
            fork
                moveItem(0, itemIndexT'(idxC), 10'sd7, -10'sd3, 1'b1, 1'b1);
                moveItem(1, itemIndexT'(idxC), -10'sd20, 10'sd40, 1'b1, 1'b1);
            join
            readCheck(0, itemIndexT'(idxC));
            readCheck(1, itemIndexT'(idxC));
        end
        endTest("concurrent moves");

        beginTest();
        moveItem(0, 5'd25, 10'sd16, 10'sd16, 1'b1, 1'b1);
        readCheck(1, 5'd25);
        endTest("move to unused entry");

        errorCount += u_itemMapTop.u_tableArbiter.u_itemMapSva.failCount;
        $display("tests run %0d, tests failed %0d, checks failed %0d",
            testCount, testsFailed, errorCount);
        if (errorCount == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* tb/itemMap_sva.sv */
module itemMapSva (
    input logic                 clock,
    input logic                 generateEn,
    input itemMapPkg::tableReqT placerReq,
    input itemMapPkg::tableReqT hookReq0,
    input itemMapPkg::tableReqT hookReq1,
    input logic                 placerGrant,
    input logic                 hookGrant0,
    input logic                 hookGrant1
);
    timeunit 1ns;
    timeprecision 100ps;

    // failed assertions so far
    int failCount = 0;

    // owner keeps the table while its request stays valid
    holdGrant: assert property (@(posedge clock) disable iff (!generateEn)
        (!$past(placerGrant) || !placerReq.valid || placerGrant) &&
        (!$past(hookGrant0) || !hookReq0.valid || hookGrant0) &&
        (!$past(hookGrant1) || !hookReq1.valid || hookGrant1))
        else begin
            $error("grant lost while the request was still valid");
            failCount++;
        end

    // grant only for a live request
    grantValid: assert property (@(posedge clock) disable iff (!generateEn)
        (!placerGrant || placerReq.valid) && (!hookGrant0 || hookReq0.valid) &&
        (!hookGrant1 || hookReq1.valid))
        else begin
            $error("grant given to an idle requester");
            failCount++;
        end

    // placer beats both hooks
    placerFirst: assert property (@(posedge clock) disable iff (!generateEn)
        placerReq.valid |-> !hookGrant0 && !hookGrant1)
        else begin
            $error("hook granted while the placer requests");
            failCount++;
        end

endmodule

bind tableArbiter itemMapSva u_itemMapSva (
    .clock       (clock),
    .generateEn  (generateEn),
    .placerReq   (placerReq),
    .hookReq0    (hookReq0),
    .hookReq1    (hookReq1),
    .placerGrant (placerGrant),
    .hookGrant0  (hookGrant0),
    .hookGrant1  (hookGrant1)
);
